//--- flist.f
+incdir+bench
source/procPkg.sv
source/stepController.sv
source/registerFile.sv
source/aluUnit.sv
source/busProcessor.sv
bench/busProcessorTb.sv

//--- bench/tbVectors.svh
// Directed vectors for the bus processor testbench
// Covers ld, cp, every ALU operation, shift edge cases, addi, subi
// and the reserved codes
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row holds instWord, dataWord, retire cycles, writeValid, writeAddr and writeValue
// Register ops pack {mode, Rx, Ry, opcode} and addi and subi pack {mode, Rx, imm}
task automatic loadVectors();
    addRow({2'b00, 2'd1, 2'd0, 4'h1}, 10'h000, 1, 1'b1, 2'd1, 10'h000);    // cp R1 from cleared R0
    addRow({2'b00, 2'd0, 2'd0, 4'h0}, 10'h155, 1, 1'b1, 2'd0, 10'h155);    // ld R0
    addRow({2'b00, 2'd1, 2'd0, 4'h0}, 10'h0A3, 1, 1'b1, 2'd1, 10'h0A3);    // ld R1
    addRow({2'b00, 2'd2, 2'd0, 4'h0}, 10'h003, 1, 1'b1, 2'd2, 10'h003);    // ld R2
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h200, 1, 1'b1, 2'd3, 10'h200);    // ld R3
    addRow({2'b00, 2'd0, 2'd1, 4'h2}, 10'h000, 3, 1'b1, 2'd0, 10'h1F8);    // add
    addRow({2'b00, 2'd1, 2'd0, 4'h3}, 10'h000, 3, 1'b1, 2'd1, 10'h2AB);    // sub wraps below zero
    addRow({2'b00, 2'd0, 2'd1, 4'h6}, 10'h000, 3, 1'b1, 2'd0, 10'h0A8);    // and
    addRow({2'b00, 2'd2, 2'd3, 4'h7}, 10'h000, 3, 1'b1, 2'd2, 10'h203);    // or
    addRow({2'b00, 2'd3, 2'd1, 4'h8}, 10'h000, 3, 1'b1, 2'd3, 10'h0AB);    // xor
    addRow({2'b00, 2'd0, 2'd2, 4'h5}, 10'h000, 3, 1'b1, 2'd0, 10'h1FC);    // flp
    addRow({2'b00, 2'd1, 2'd0, 4'h0}, 10'h000, 1, 1'b1, 2'd1, 10'h000);    // ld R1 zero
    addRow({2'b00, 2'd2, 2'd1, 4'h4}, 10'h000, 3, 1'b1, 2'd2, 10'h000);    // inv of 0
    addRow({2'b00, 2'd2, 2'd0, 4'h4}, 10'h000, 3, 1'b1, 2'd2, 10'h204);    // inv
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);    // Negative shift source
    addRow({2'b00, 2'd3, 2'd1, 4'h9}, 10'h000, 3, 1'b1, 2'd3, 10'h2C5);    // lsl by 0
    addRow({2'b00, 2'd3, 2'd1, 4'hA}, 10'h000, 3, 1'b1, 2'd3, 10'h2C5);    // lsr by 0
    addRow({2'b00, 2'd3, 2'd1, 4'hB}, 10'h000, 3, 1'b1, 2'd3, 10'h2C5);    // asr by 0
    addRow({2'b00, 2'd1, 2'd0, 4'h0}, 10'h009, 1, 1'b1, 2'd1, 10'h009);    // Shift amount 9
    addRow({2'b00, 2'd3, 2'd1, 4'h9}, 10'h000, 3, 1'b1, 2'd3, 10'h200);    // lsl by 9
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hA}, 10'h000, 3, 1'b1, 2'd3, 10'h001);    // lsr by 9
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hB}, 10'h000, 3, 1'b1, 2'd3, 10'h3FF);    // asr by 9
    addRow({2'b00, 2'd1, 2'd0, 4'h0}, 10'h00A, 1, 1'b1, 2'd1, 10'h00A);    // Shift amount 10
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'h9}, 10'h000, 3, 1'b1, 2'd3, 10'h000);    // lsl by 10
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hA}, 10'h000, 3, 1'b1, 2'd3, 10'h000);    // lsr by 10
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hB}, 10'h000, 3, 1'b1, 2'd3, 10'h3FF);    // asr by 10 with sign set
    addRow({2'b00, 2'd1, 2'd0, 4'h0}, 10'h3F0, 1, 1'b1, 2'd1, 10'h3F0);    // Huge shift amount
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h0C5, 1, 1'b1, 2'd3, 10'h0C5);    // Positive source
    addRow({2'b00, 2'd3, 2'd1, 4'hB}, 10'h000, 3, 1'b1, 2'd3, 10'h000);    // asr with sign clear
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'h9}, 10'h000, 3, 1'b1, 2'd3, 10'h000);    // lsl by huge amount
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hA}, 10'h000, 3, 1'b1, 2'd3, 10'h000);    // lsr by huge amount
    addRow({2'b00, 2'd3, 2'd0, 4'h0}, 10'h2C5, 1, 1'b1, 2'd3, 10'h2C5);
    addRow({2'b00, 2'd3, 2'd1, 4'hB}, 10'h000, 3, 1'b1, 2'd3, 10'h3FF);    // asr by huge amount
    addRow({2'b00, 2'd2, 2'd0, 4'h0}, 10'h3F0, 1, 1'b1, 2'd2, 10'h3F0);
    addRow({2'b10, 2'd2, 6'h3F}, 10'h000, 3, 1'b1, 2'd2, 10'h02F);          // addi wraps
    addRow({2'b11, 2'd2, 6'h30}, 10'h000, 3, 1'b1, 2'd2, 10'h3FF);          // subi wraps
    addRow({2'b10, 2'd2, 6'h01}, 10'h000, 3, 1'b1, 2'd2, 10'h000);          // addi to zero
    addRow({2'b01, 2'd0, 2'd1, 4'h0}, 10'h155, 1, 1'b0, 2'd0, 10'h000);    // Reserved mode
    addRow({2'b00, 2'd0, 2'd1, 4'hC}, 10'h000, 1, 1'b0, 2'd0, 10'h000);    // Reserved opcode 12
    addRow({2'b00, 2'd1, 2'd0, 4'hD}, 10'h000, 1, 1'b0, 2'd0, 10'h000);    // Reserved opcode 13
    addRow({2'b00, 2'd3, 2'd0, 4'h1}, 10'h000, 1, 1'b1, 2'd3, 10'h1FC);    // R0 untouched
    addRow({2'b00, 2'd2, 2'd1, 4'h1}, 10'h000, 1, 1'b1, 2'd2, 10'h3F0);    // R1 untouched
endtask

`endif

//--- bench/busProcessorTb.sv
// Testbench for the 10-bit bus processor core
// Sends a directed table and an LFSR-driven random stream under credit
// flow control and checks every retirement against a register model
`timescale 1ns/100ps
`default_nettype none

module busProcessorTb;
    import procPkg::*;

    localparam int clkPeriod   = 40;
    localparam int waitLimit   = 20;        // Cycles allowed until credit return
    localparam int randomCount = 40;

    logic    clk;
    logic    reset;
    logic    instValid;
    instT    instWord;
    wordT    dataWord;
    logic    creditReturn;
    logic    writeValid;
    regAddrT writeAddr;
    wordT    writeValue;

    instT        vecInst [$];               // Directed table columns
    wordT        vecData [$];
    int          vecLat [$];
    logic        vecValid [$];
    regAddrT     vecAddr [$];
    wordT        vecValue [$];
    wordT        modelRegs [regCount];      // Reference register contents
    logic [15:0] lfsrState;
    int          credits;
    int          testCount;
    int          failCount;
    int          errCount;                  // Errors within the running test
    logic        timedOut;

    busProcessor i_busProcessor (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .instWord     (instWord),
        .dataWord     (dataWord),
        .creditReturn (creditReturn),
        .writeValid   (writeValid),
        .writeAddr    (writeAddr),
        .writeValue   (writeValue)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic addRow(input instT inst, input wordT data, input int lat,
                          input logic wv, input regAddrT wa, input wordT wval);
        vecInst.push_back(inst);
        vecData.push_back(data);
        vecLat.push_back(lat);
        vecValid.push_back(wv);
        vecAddr.push_back(wa);
        vecValue.push_back(wval);
    endtask

    `include "tbVectors.svh"

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            errCount++;
        end
    endtask

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrState[0]};    // One LFSR step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Register model, updated as the instruction retires
    task automatic predict(input instT inst, input wordT data, output int lat,
                           output logic wv, output regAddrT wa, output wordT wval);
        instModeT mode;
        aluOpT    op;
        wordT     a;
        wordT     b;
        wordT     imm;
        mode = instModeT'(inst[modeMsb -: 2]);
        op   = aluOpT'(inst[opMsb -: 4]);
        wa   = inst[rxMsb -: 2];
        a    = modelRegs[wa];
        b    = modelRegs[inst[ryMsb -: 2]];
        imm  = {4'b0000, inst[immMsb -: 6]};
        lat  = 3;
        wv   = 1'b1;
        wval = '0;
        case (mode)
            modeRsvd: begin
                lat = 1;
                wv  = 1'b0;
            end
            modeAddi: wval = a + imm;
            modeSubi: wval = a - imm;
            default: begin
                case (op)
                    opLoad: begin
                        lat  = 1;
                        wval = data;
                    end
                    opCopy: begin
                        lat  = 1;
                        wval = b;
                    end
                    opAdd:  wval = a + b;
                    opSub:  wval = a - b;
                    opInv:  wval = 10'd0 - b;
                    opFlip: wval = b ^ 10'h3FF;
                    opAnd:  wval = a & b;
                    opOr:   wval = a | b;
                    opXor:  wval = a ^ b;
                    opLsl:  wval = (b >= 10) ? 10'd0 : (a << b);
                    opLsr:  wval = (b >= 10) ? 10'd0 : (a >> b);
                    opAsr: begin
                        if (b >= 10) begin
                            wval = {10{a[9]}};
                        end else begin
                            wval = (a >> b) | (a[9] ? ~(10'h3FF >> b) : 10'd0);  // Sign fill
                        end
                    end
                    default: begin
                        lat = 1;                // Reserved opcodes
                        wv  = 1'b0;
                    end
                endcase
            end
        endcase
        if (wv) begin
            modelRegs[wa] = wval;
        end
    endtask

    task automatic reportTest(input string tag);
        testCount++;
        if (errCount == 0) begin
            $display("test %0d %s ok", testCount, tag);
        end else begin
            $display("test %0d %s FAILED with %0d errors", testCount, tag, errCount);
            failCount++;
        end
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic runTest(input string tag, input instT inst, input wordT data,
                           input int expLat, input logic expValid,
                           input regAddrT expAddr, input wordT expValue);
        int   cycles;
        logic retired;
        if (timedOut) begin
            return;
        end
        errCount = 0;
        if (credits < 1) begin
            $display("Sender holds no credit at t=%0t, instruction not sent", $time);
            errCount++;
            reportTest(tag);
            return;
        end
        instWord  = inst;
        dataWord  = data;
        instValid = 1'b1;
        credits--;
        @(posedge clk);                     // Acceptance edge
        #2;
        instValid = 1'b0;
        cycles    = 0;
        retired   = 1'b0;
        while (!retired && cycles < waitLimit) begin
            @(negedge clk);                 // Mid-cycle, outputs settled
            cycles++;
            if (creditReturn) begin
                retired = 1'b1;
            end else if (writeValid) begin
                $display("Register write at t=%0t before the instruction retired", $time);
                errCount++;
            end
        end
        if (!retired) begin
            $display("No credit return within %0d cycles for inst %h", waitLimit, inst);
            timedOut = 1'b1;
            testCount++;
            failCount++;
            return;
        end
        credits++;
        if (cycles != expLat) begin
            $display("Inst %h retired %0d cycles after acceptance instead of %0d",
                     inst, cycles, expLat);
            errCount++;
        end
        checkBit("writeValid", writeValid, expValid);
        if (expValid) begin
            checkAddr("writeAddr", writeAddr, expAddr);
            checkWord("writeValue", writeValue, expValue);
        end
        @(posedge clk);                     // Write-back edge
        #2;
        reportTest(tag);
    endtask

    initial begin
        logic [15:0] rnd;
        int          lat;
        logic        wv;
        regAddrT     wa;
        wordT        wval;
        instT        inst;
        wordT        data;
        clk       = 1'b0;
        reset     = 1'b1;
        instValid = 1'b0;
        instWord  = '0;
        dataWord  = '0;
        lfsrState = 16'd70;
        credits   = creditDepth;
        testCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        loadVectors();
        repeat (5) @(posedge clk);
        #2;
        reset    = 1'b0;
        errCount = 0;
        repeat (5) begin                    // Quiet outputs while idle
            @(negedge clk);
            checkBit("creditReturn", creditReturn, 1'b0);
            checkBit("writeValid", writeValid, 1'b0);
        end
        @(posedge clk);
        #2;
        reportTest("idle");
        for (int i = 0; i < vecInst.size(); i++) begin
            predict(vecInst[i], vecData[i], lat, wv, wa, wval);     // Keeps model in step
            runTest("directed", vecInst[i], vecData[i], vecLat[i], vecValid[i],
                    vecAddr[i], vecValue[i]);
        end
        for (int i = 0; i < randomCount; i++) begin
            takeBits(10, rnd);
            inst = rnd[9:0];
            takeBits(10, rnd);
            data = rnd[9:0];
            predict(inst, data, lat, wv, wa, wval);
            runTest("random", inst, data, lat, wv, wa, wval);
        end
        $display("Tests run %0d, failed %0d", testCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/busProcessor.sv
// Top level of the 10-bit bus processor core
// Connects the timestep controller, register file and ALU unit,
// multiplexes the shared bus and exposes register write-backs
`timescale 1ns/100ps
`default_nettype none

module busProcessor (
    input  logic             clk,
    input  logic             reset,
    input  logic             instValid,     // Sent only while holding a credit
    input  procPkg::instT    instWord,
    input  procPkg::wordT    dataWord,      // Data for ld
    output logic             creditReturn,  // Instruction retired
    output logic             writeValid,    // Register write this cycle
    output procPkg::regAddrT writeAddr,
    output procPkg::wordT    writeValue
);
    import procPkg::*;

    logic    rdEn;
    logic    wrEn;
    logic    aLoad;
    logic    gLoad;
    regAddrT rdAddr;
    regAddrT wrAddr;
    aluOpT   aluOp;
    busSelT  busSel;
    wordT    immValue;
    wordT    extValue;
    wordT    rdData;
    wordT    gValue;
    wordT    bus;                           // Shared data bus

    stepController i_stepController (
        .clk          (clk),
        .reset        (reset),
        .instValid    (instValid),
        .instWord     (instWord),
        .dataWord     (dataWord),
        .creditReturn (creditReturn),
        .rdEn         (rdEn),
        .wrEn         (wrEn),
        .aLoad        (aLoad),
        .gLoad        (gLoad),
        .rdAddr       (rdAddr),
        .wrAddr       (wrAddr),
        .aluOp        (aluOp),
        .busSel       (busSel),
        .immValue     (immValue),
        .extValue     (extValue)
    );

    registerFile i_registerFile (
        .clk    (clk),
        .reset  (reset),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .busIn  (bus),
        .rdData (rdData)
    );

    aluUnit i_aluUnit (
        .clk    (clk),
        .reset  (reset),
        .aLoad  (aLoad),
        .gLoad  (gLoad),
        .aluOp  (aluOp),
        .busIn  (bus),
        .gValue (gValue)
    );

    // Bus multiplexer in place of tristate drivers
    always_comb begin
        case (busSel)
            selReg:  bus = rdData;
            selG:    bus = gValue;
            selExt:  bus = extValue;
            selImm:  bus = immValue;
            default: bus = '0;              // Idle bus
        endcase
    end

    assign writeValid = wrEn;
    assign writeAddr  = wrAddr;
    assign writeValue = bus;                // Value taken by Rx at the next edge

endmodule

`default_nettype wire

//--- source/aluUnit.sv
// ALU unit of the bus processor
// A register latches the first operand from the bus, the ALU combines
// A with the bus value, and G holds the result until write-back
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  logic           clk,
    input  logic           reset,
    input  logic           aLoad,           // A takes the bus
    input  logic           gLoad,           // G takes the ALU result
    input  procPkg::aluOpT aluOp,
    input  procPkg::wordT  busIn,
    output procPkg::wordT  gValue
);
    import procPkg::*;

    wordT       aReg;                       // First operand
    wordT       gReg;                       // Result register
    wordT       result;
    wordT       signFill;                   // All bits equal to A sign
    logic       overShift;                  // Shift amount of a full word or more
    logic [3:0] shiftAmt;

    assign overShift = (busIn >= wordT'(wordW));
    assign shiftAmt  = busIn[3:0];          // Only meaningful when not overShift
    assign signFill  = {wordW{aReg[wordW-1]}};

    always_comb begin
        case (aluOp)
            opAdd:  result = aReg + busIn;  // Wraps modulo 1024
            opSub:  result = aReg - busIn;
            opInv:  result = -busIn;        // Twos complement of Ry
            opFlip: result = ~busIn;
            opAnd:  result = aReg & busIn;
            opOr:   result = aReg | busIn;
            opXor:  result = aReg ^ busIn;
            opLsl: begin
                if (overShift) begin
                    result = '0;
                end else begin
                    result = aReg << shiftAmt;
                end
            end
            opLsr: begin
                if (overShift) begin
                    result = '0;
                end else begin
                    result = aReg >> shiftAmt;
                end
            end
            opAsr: begin
                if (overShift) begin
                    result = signFill;      // Everything shifted out but the sign
                end else begin
                    result = wordT'($signed(aReg) >>> shiftAmt);
                end
            end
            default: result = busIn;        // ld, cp and reserved pass the bus
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aReg <= '0;
        end else if (aLoad) begin
            aReg <= busIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gReg <= '0;
        end else if (gLoad) begin
            gReg <= result;                 // One cycle from operands to G
        end
    end

    assign gValue = gReg;

    // A and G load in different timesteps of the same instruction
    splitLoads: assert property (@(posedge clk) disable iff (reset)
        !(aLoad && gLoad));

endmodule

`default_nettype wire

//--- source/registerFile.sv
// Register file of the bus processor
// Four 10-bit registers, one read port onto the bus and one write port
// from the bus
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  logic             rdEn,          // Drive rdData from rdAddr
    input  procPkg::regAddrT rdAddr,
    input  logic             wrEn,          // Write busIn at the edge
    input  procPkg::regAddrT wrAddr,
    input  procPkg::wordT    busIn,
    output procPkg::wordT    rdData
);
    import procPkg::*;

    wordT regs [regCount];                  // R0..R3

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= busIn;
        end
    end

    // Combinational read, zero when not selected
    assign rdData = rdEn ? regs[rdAddr] : '0;

    // Controller must always hand over a defined target register
    knownWrAddr: assert property (@(posedge clk) disable iff (reset)
        wrEn |-> !$isunknown(wrAddr));

endmodule

`default_nettype wire

//--- source/stepController.sv
// Timestep controller for the bus processor
// Latches the accepted instruction and data word, steps T0..T3 and
// decodes mode, opcode and step into bus, register and ALU controls
`timescale 1ns/100ps
`default_nettype none

module stepController (
    input  logic            clk,
    input  logic            reset,
    input  logic            instValid,      // One-cycle strobe that spends a credit
    input  procPkg::instT   instWord,
    input  procPkg::wordT   dataWord,
    output logic            creditReturn,   // Pulses in the retire cycle
    output logic            rdEn,           // Register file drives the bus
    output logic            wrEn,           // Register file takes the bus
    output logic            aLoad,          // A register takes the bus
    output logic            gLoad,          // G register takes the ALU result
    output procPkg::regAddrT rdAddr,
    output procPkg::regAddrT wrAddr,
    output procPkg::aluOpT  aluOp,
    output procPkg::busSelT busSel,
    output procPkg::wordT   immValue,       // Zero-extended immediate
    output procPkg::wordT   extValue        // Latched external data
);
    import procPkg::*;

    instT     instReg;                      // Instruction register
    wordT     dataReg;                      // External data latch
    stepT     step;                         // Current timestep
    stepT     stepNext;
    instModeT mode;
    aluOpT    opField;
    regAddrT  rx;
    regAddrT  ry;
    immT      imm;
    logic     isNop;                        // Reserved mode or opcode
    logic     isShort;                      // Finishes in T1
    logic     accept;

    // Field split of the latched instruction
    assign mode    = instModeT'(instReg[modeMsb -: $bits(instModeT)]);
    assign rx      = instReg[rxMsb -: $bits(regAddrT)];
    assign ry      = instReg[ryMsb -: $bits(regAddrT)];
    assign opField = aluOpT'(instReg[opMsb -: $bits(aluOpT)]);
    assign imm     = instReg[immMsb -: $bits(immT)];

    assign isNop   = (mode == modeRsvd) ||
                     (mode == modeReg && opField inside {opRsvd12, opRsvd13, opRsvd14, opRsvd15});
    assign isShort = isNop || (mode == modeReg && opField inside {opLoad, opCopy});

    assign accept   = (step == stepT0) && instValid;
    assign immValue = wordT'(imm);          // Pad upper bits with zeros
    assign extValue = dataReg;

    // Payload latches load only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            instReg <= instWord;
            dataReg <= dataWord;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= stepT0;
        end else begin
            step <= stepNext;
        end
    end

    always_comb begin
        stepNext = step;
        case (step)
            stepT0: if (instValid) stepNext = stepT1;
            stepT1: stepNext = isShort ? stepT0 : stepT2;   // ld, cp, no-op retire here
            stepT2: stepNext = stepT3;
            stepT3: stepNext = stepT0;                      // Write-back done
            default: stepNext = stepT0;
        endcase
    end

    // Time-instruction table
    always_comb begin
        creditReturn = 1'b0;
        rdEn         = 1'b0;
        wrEn         = 1'b0;
        aLoad        = 1'b0;
        gLoad        = 1'b0;
        rdAddr       = '0;
        wrAddr       = '0;
        aluOp        = opLoad;
        busSel       = selNone;

        case (step)
            stepT1: begin
                if (isNop) begin
                    creditReturn = 1'b1;            // No write-back
                end else if (mode == modeReg && opField == opLoad) begin
                    busSel       = selExt;          // Data word onto the bus
                    wrAddr       = rx;
                    wrEn         = 1'b1;
                    creditReturn = 1'b1;
                end else if (mode == modeReg && opField == opCopy) begin
                    rdAddr       = ry;
                    rdEn         = 1'b1;
                    busSel       = selReg;
                    wrAddr       = rx;
                    wrEn         = 1'b1;
                    creditReturn = 1'b1;
                end else begin
                    rdAddr       = rx;              // First operand into A
                    rdEn         = 1'b1;
                    busSel       = selReg;
                    aLoad        = 1'b1;
                end
            end
            stepT2: begin
                gLoad = 1'b1;
                case (mode)
                    modeAddi: begin
                        busSel = selImm;
                        aluOp  = opAdd;
                    end
                    modeSubi: begin
                        busSel = selImm;
                        aluOp  = opSub;
                    end
                    default: begin
                        rdAddr = ry;                // Second operand straight to the ALU
                        rdEn   = 1'b1;
                        busSel = selReg;
                        aluOp  = opField;
                    end
                endcase
            end
            stepT3: begin
                busSel       = selG;                // Result back to Rx
                wrAddr       = rx;
                wrEn         = 1'b1;
                creditReturn = 1'b1;
            end
            default: ;                              // T0 idle
        endcase
    end

    // A second instruction before retirement means the sender overspent its credit
    creditHonored: assert property (@(posedge clk) disable iff (reset)
        instValid |-> step == stepT0);

    // G only owns the bus in the cycle right after it took a result
    gResultFresh: assert property (@(posedge clk) disable iff (reset)
        busSel == selG |-> $past(gLoad));

endmodule

`default_nettype wire

//--- source/procPkg.sv
// Shared definitions for the 10-bit bus processor core
// Word and field types, opcode, mode, timestep and bus select enums,
// instruction field positions and the sender credit depth
`default_nettype none

package procPkg;

    localparam int wordW = 10;                  // Bus and register width
    localparam int regCount = 4;                // Registers in the file

    typedef logic [wordW-1:0] wordT;            // One bus word
    typedef logic [1:0]       regAddrT;         // Register index
    typedef logic [9:0]       instT;            // One instruction word
    typedef logic [5:0]       immT;             // Raw immediate field

    // Low nibble of a register-register instruction
    typedef enum logic [3:0] {
        opLoad   = 4'b0000,                     // Rx <- data
        opCopy   = 4'b0001,                     // Rx <- Ry
        opAdd    = 4'b0010,                     // Rx <- Rx + Ry
        opSub    = 4'b0011,                     // Rx <- Rx - Ry
        opInv    = 4'b0100,                     // Rx <- -Ry
        opFlip   = 4'b0101,                     // Rx <- ~Ry
        opAnd    = 4'b0110,
        opOr     = 4'b0111,
        opXor    = 4'b1000,
        opLsl    = 4'b1001,                     // Rx <- Rx << Ry
        opLsr    = 4'b1010,                     // Rx <- Rx >> Ry
        opAsr    = 4'b1011,                     // Rx <- Rx >>> Ry
        opRsvd12 = 4'b1100,                     // Retires as no-op
        opRsvd13 = 4'b1101,                     // Retires as no-op
        opRsvd14 = 4'b1110,
        opRsvd15 = 4'b1111
    } aluOpT;

    // Top two bits of the instruction
    typedef enum logic [1:0] {
        modeReg  = 2'b00,                       // Register-register group
        modeRsvd = 2'b01,                       // No-op
        modeAddi = 2'b10,                       // Rx <- Rx + imm
        modeSubi = 2'b11                        // Rx <- Rx - imm
    } instModeT;

    typedef enum logic [1:0] {
        stepT0,                                 // Idle, waiting for an instruction
        stepT1,
        stepT2,
        stepT3
    } stepT;

    // Source that drives the shared bus
    typedef enum logic [2:0] {
        selNone,                                // Bus reads zero
        selReg,                                 // Register file read port
        selG,                                   // ALU result register
        selExt,                                 // Latched external data
        selImm                                  // Zero-extended immediate
    } busSelT;

    localparam int modeMsb = 9;                 // Mode field [9:8]
    localparam int rxMsb   = 7;                 // Rx field [7:6]
    localparam int ryMsb   = 5;                 // Ry field [5:4]
    localparam int opMsb   = 3;                 // Opcode field [3:0]
    localparam int immMsb  = 5;                 // Immediate field [5:0]

    localparam int creditDepth = 1;             // Instructions the sender may have outstanding

endpackage

`default_nettype wire
